// File: cmac_pkg.sv
// cmac shared definitions
// sizes, descriptor fields, element types and control states
`default_nettype none

package cmac_pkg;

  // ==================================================
  // array geometry
  // ==================================================
  // channels per beat
  parameter int CMAC_ATOMC = 8;
  // bits per element
  parameter int CMAC_BPE = 8;
  // number of mac cells
  parameter int CMAC_ATOMK = 4;
  // 16-bit products plus 3 bits of growth for 8 terms
  parameter int CMAC_RESULT_WIDTH = 2 * CMAC_BPE + 3;

  // ==================================================
  // descriptor
  // ==================================================
  parameter int CMAC_PD_WIDTH = 9;
  // marker bits, the rest is opaque
  parameter int PD_STRIPE_ST = 5;
  parameter int PD_STRIPE_END = 6;
  parameter int PD_LAYER_END = 8;

  // ==================================================
  // element types
  // ==================================================
  // one signed int8 element
  typedef logic signed [CMAC_BPE-1:0] elem_t;
  // one beat, channel 0 in the low byte
  typedef elem_t [CMAC_ATOMC-1:0] beat_t;
  // signed dot product
  typedef logic signed [CMAC_RESULT_WIDTH-1:0] result_t;

  // op_en/done sequencing
  typedef enum logic [1:0] {
    CFG_IDLE = 2'd0,
    CFG_RUN  = 2'd1,
    CFG_DONE = 2'd2
  } cfg_state_e;

endpackage

`default_nettype wire

// File: cmac_if.sv
// cmac internal stream bundles
// retimed data and weight beats, per-cell operand feed
`timescale 1ns/1ps
`default_nettype none

// retimed feature data beat
interface cmac_dat_if;
  logic                                 pvld;
  logic [cmac_pkg::CMAC_ATOMC-1:0]      mask;
  cmac_pkg::beat_t                      data;
  logic [cmac_pkg::CMAC_PD_WIDTH-1:0]   pd;

  modport src (output pvld, mask, data, pd);
  modport dst (input pvld, mask, data, pd);
endinterface

// retimed weight beat, sel is one-hot over cells
interface cmac_wt_if;
  logic                                 pvld;
  logic [cmac_pkg::CMAC_ATOMC-1:0]      mask;
  cmac_pkg::beat_t                      data;
  logic [cmac_pkg::CMAC_ATOMK-1:0]      sel;

  modport src (output pvld, mask, data, sel);
  modport dst (input pvld, mask, data, sel);
endinterface

// operands for one mac cell
interface cmac_op_if;
  logic                                 pvld;
  cmac_pkg::beat_t                      dat;
  logic [cmac_pkg::CMAC_ATOMC-1:0]      dat_nz;
  cmac_pkg::beat_t                      wt;
  logic [cmac_pkg::CMAC_ATOMC-1:0]      wt_nz;

  modport src (output pvld, dat, dat_nz, wt, wt_nz);
  modport dst (input pvld, dat, dat_nz, wt, wt_nz);
endinterface

`default_nettype wire

// File: cmac_cfg.sv
// cmac operation control
// four-phase op_en/done handshake, op start pulse and running level
`timescale 1ns/1ps
`default_nettype none

module cmac_cfg (
  input  logic nvdla_core_clk,
  input  logic rst_n,
  input  logic reg2dp_op_en,
  input  logic out_layer_end,
  output logic dp2reg_done,
  output logic op_start,
  output logic op_running
);

  cmac_pkg::cfg_state_e state;
  cmac_pkg::cfg_state_e state_nxt;
  logic                 op_en_q;

  // previous op_en for edge detect
  always_ff @(posedge nvdla_core_clk) begin
    if (!rst_n) begin
      op_en_q <= 1'b0;
    end else begin
      op_en_q <= reg2dp_op_en;
    end
  end

  // request rising while idle
  assign op_start = (state == cmac_pkg::CFG_IDLE) && reg2dp_op_en && !op_en_q;

  always_comb begin
    state_nxt = state;
    case (state)
      cmac_pkg::CFG_IDLE: if (op_start) state_nxt = cmac_pkg::CFG_RUN;
      // layer end beat has left the core
      cmac_pkg::CFG_RUN:  if (out_layer_end) state_nxt = cmac_pkg::CFG_DONE;
      // hold ack until the request drops
      cmac_pkg::CFG_DONE: if (!reg2dp_op_en) state_nxt = cmac_pkg::CFG_IDLE;
      default:            state_nxt = cmac_pkg::CFG_IDLE;
    endcase
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (!rst_n) begin
      state <= cmac_pkg::CFG_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  assign op_running  = (state == cmac_pkg::CFG_RUN);
  assign dp2reg_done = (state == cmac_pkg::CFG_DONE);

endmodule

`default_nettype wire

// File: cmac_rt_in.sv
// cmac input retiming
// delays data and weight streams by RT_IN_STAGES, data gated by op running
`timescale 1ns/1ps
`default_nettype none

module cmac_rt_in #(
  parameter int RT_IN_STAGES = 1
) (
  input  logic                                   nvdla_core_clk,
  input  logic                                   rst_n,
  input  logic                                   op_running,
  input  logic                                   sc2mac_dat_pvld,
  input  logic [cmac_pkg::CMAC_ATOMC-1:0]        sc2mac_dat_mask,
  input  cmac_pkg::beat_t                        sc2mac_dat_data,
  input  logic [cmac_pkg::CMAC_PD_WIDTH-1:0]     sc2mac_dat_pd,
  input  logic                                   sc2mac_wt_pvld,
  input  logic [cmac_pkg::CMAC_ATOMC-1:0]        sc2mac_wt_mask,
  input  cmac_pkg::beat_t                        sc2mac_wt_data,
  input  logic [cmac_pkg::CMAC_ATOMK-1:0]        sc2mac_wt_sel,
  cmac_dat_if.src                                dat,
  cmac_wt_if.src                                 wt
);

  localparam int S = RT_IN_STAGES;

  logic [S-1:0]                         dat_vld;
  logic [cmac_pkg::CMAC_ATOMC-1:0]      dat_mask_q [S];
  cmac_pkg::beat_t                      dat_data_q [S];
  logic [cmac_pkg::CMAC_PD_WIDTH-1:0]   dat_pd_q [S];
  logic [S-1:0]                         wt_vld;
  logic [cmac_pkg::CMAC_ATOMC-1:0]      wt_mask_q [S];
  cmac_pkg::beat_t                      wt_data_q [S];
  logic [cmac_pkg::CMAC_ATOMK-1:0]      wt_sel_q [S];

  // ==================================================
  // valid chains
  // ==================================================
  always_ff @(posedge nvdla_core_clk) begin
    if (!rst_n) begin
      dat_vld <= '0;
      wt_vld  <= '0;
    end else begin
      // data only enters while an op runs
      dat_vld[0] <= sc2mac_dat_pvld & op_running;
      wt_vld[0]  <= sc2mac_wt_pvld;
      for (int s = 1; s < S; s++) begin
        dat_vld[s] <= dat_vld[s-1];
        wt_vld[s]  <= wt_vld[s-1];
      end
    end
  end

  // ==================================================
  // payload, loads on valid only
  // ==================================================
  always_ff @(posedge nvdla_core_clk) begin
    if (sc2mac_dat_pvld) begin
      dat_mask_q[0] <= sc2mac_dat_mask;
      dat_data_q[0] <= sc2mac_dat_data;
      dat_pd_q[0]   <= sc2mac_dat_pd;
    end
    if (sc2mac_wt_pvld) begin
      wt_mask_q[0] <= sc2mac_wt_mask;
      wt_data_q[0] <= sc2mac_wt_data;
      wt_sel_q[0]  <= sc2mac_wt_sel;
    end
    for (int s = 1; s < S; s++) begin
      if (dat_vld[s-1]) begin
        dat_mask_q[s] <= dat_mask_q[s-1];
        dat_data_q[s] <= dat_data_q[s-1];
        dat_pd_q[s]   <= dat_pd_q[s-1];
      end
      if (wt_vld[s-1]) begin
        wt_mask_q[s] <= wt_mask_q[s-1];
        wt_data_q[s] <= wt_data_q[s-1];
        wt_sel_q[s]  <= wt_sel_q[s-1];
      end
    end
  end

  assign dat.pvld = dat_vld[S-1];
  assign dat.mask = dat_mask_q[S-1];
  assign dat.data = dat_data_q[S-1];
  assign dat.pd   = dat_pd_q[S-1];
  assign wt.pvld  = wt_vld[S-1];
  assign wt.mask  = wt_mask_q[S-1];
  assign wt.data  = wt_data_q[S-1];
  assign wt.sel   = wt_sel_q[S-1];

endmodule

`default_nettype wire

// File: cmac_active.sv
// cmac shadow and active weight banks
// stages data beats and feeds each cell, pd delay line matches cell latency
`timescale 1ns/1ps
`default_nettype none

module cmac_active (
  input  logic                                   nvdla_core_clk,
  input  logic                                   rst_n,
  input  logic                                   op_start,
  cmac_dat_if.dst                                dat,
  cmac_wt_if.dst                                 wt,
  cmac_op_if.src                                 op [cmac_pkg::CMAC_ATOMK],
  output logic [cmac_pkg::CMAC_ATOMK-1:0]        cell_loaded,
  output logic [cmac_pkg::CMAC_PD_WIDTH-1:0]     out_pd,
  output logic                                   out_pvld
);

  localparam int C = cmac_pkg::CMAC_ATOMC;
  localparam int K = cmac_pkg::CMAC_ATOMK;

  logic                                 promote;
  logic [C-1:0]                         dat_nz_in;
  logic [C-1:0]                         wt_nz_in;
  cmac_pkg::beat_t                      wt_sd [K];
  cmac_pkg::beat_t                      wt_actv [K];
  logic [C-1:0]                         wt_sd_nz [K];
  logic [C-1:0]                         wt_actv_nz [K];
  logic [K-1:0]                         sd_written;
  logic [K-1:0]                         loaded;
  logic                                 dat_pvld_q;
  cmac_pkg::beat_t                      dat_q;
  logic [C-1:0]                         dat_nz_q;
  logic [cmac_pkg::CMAC_PD_WIDTH-1:0]   pd_q;
  logic [1:0]                           pvld_d;
  logic [cmac_pkg::CMAC_PD_WIDTH-1:0]   pd_d [2];
  logic [K-1:0]                         ld_d [2];

  // first beat of a stripe swaps banks
  assign promote = dat.pvld & dat.pd[cmac_pkg::PD_STRIPE_ST];

  // zero skip, masked or zero-valued channels
  always_comb begin
    for (int c = 0; c < C; c++) begin
      dat_nz_in[c] = dat.mask[c] && (dat.data[c] != '0);
      wt_nz_in[c]  = wt.mask[c] && (wt.data[c] != '0);
    end
  end

  // ==================================================
  // weight banks
  // ==================================================
  always_ff @(posedge nvdla_core_clk) begin
    for (int k = 0; k < K; k++) begin
      // shadow written by selected weight beats
      if (wt.pvld && wt.sel[k]) begin
        wt_sd[k]    <= wt.data;
        wt_sd_nz[k] <= wt_nz_in;
      end
      // all cells promote together
      if (promote) begin
        wt_actv[k]    <= wt_sd[k];
        wt_actv_nz[k] <= wt_sd_nz[k];
      end
    end
  end

  // written / loaded flags per cell
  always_ff @(posedge nvdla_core_clk) begin
    if (!rst_n) begin
      sd_written <= '0;
      loaded     <= '0;
    end else begin
      if (wt.pvld) begin
        sd_written <= sd_written | wt.sel;
      end
      if (op_start) begin
        loaded <= '0;
      end else if (promote) begin
        loaded <= loaded | sd_written;
      end
    end
  end

  // ==================================================
  // data staging, same edge as promotion
  // ==================================================
  always_ff @(posedge nvdla_core_clk) begin
    if (!rst_n) begin
      dat_pvld_q <= 1'b0;
    end else begin
      dat_pvld_q <= dat.pvld;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (dat.pvld) begin
      dat_q    <= dat.data;
      dat_nz_q <= dat_nz_in;
      pd_q     <= dat.pd;
    end
  end

  // fan out to cells
  for (genvar k = 0; k < K; k++) begin : g_feed
    assign op[k].pvld   = dat_pvld_q;
    assign op[k].dat    = dat_q;
    assign op[k].dat_nz = dat_nz_q;
    assign op[k].wt     = wt_actv[k];
    assign op[k].wt_nz  = wt_actv_nz[k];
  end

  // ==================================================
  // pd delay line, two cell stages
  // ==================================================
  always_ff @(posedge nvdla_core_clk) begin
    if (!rst_n) begin
      pvld_d   <= '0;
      ld_d[0]  <= '0;
      ld_d[1]  <= '0;
    end else begin
      pvld_d  <= {pvld_d[0], dat_pvld_q};
      ld_d[0] <= loaded;
      ld_d[1] <= ld_d[0];
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (dat_pvld_q) begin
      pd_d[0] <= pd_q;
    end
    if (pvld_d[0]) begin
      pd_d[1] <= pd_d[0];
    end
  end

  assign out_pvld    = pvld_d[1];
  assign out_pd      = pd_d[1];
  assign cell_loaded = ld_d[1];

endmodule

`default_nettype wire

// File: cmac_mac_cell.sv
// cmac mac cell
// two stage masked int8 dot product, products then adder tree
`timescale 1ns/1ps
`default_nettype none

module cmac_mac_cell (
  input  logic              nvdla_core_clk,
  input  logic              rst_n,
  cmac_op_if.dst            op,
  output cmac_pkg::result_t mac_out_data,
  output logic              mac_out_pvld
);

  localparam int C = cmac_pkg::CMAC_ATOMC;
  localparam int W = 2 * cmac_pkg::CMAC_BPE;

  logic signed [W-1:0]   prod [C];
  logic                  prod_pvld;
  logic signed [W:0]     sum_l1 [C/2];
  logic signed [W+1:0]   sum_l2 [C/4];
  cmac_pkg::result_t     sum_l3;

  // ==================================================
  // stage one, products
  // ==================================================
  always_ff @(posedge nvdla_core_clk) begin
    if (!rst_n) begin
      prod_pvld <= 1'b0;
    end else begin
      prod_pvld <= op.pvld;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (op.pvld) begin
      for (int c = 0; c < C; c++) begin
        // skipped channel adds nothing
        if (op.dat_nz[c] && op.wt_nz[c]) begin
          prod[c] <= $signed(op.dat[c]) * $signed(op.wt[c]);
        end else begin
          prod[c] <= '0;
        end
      end
    end
  end

  // ==================================================
  // stage two, adder tree
  // ==================================================
  always_comb begin
    // one bit growth per level
    for (int i = 0; i < C/2; i++) begin
      sum_l1[i] = prod[2*i] + prod[2*i+1];
    end
    for (int i = 0; i < C/4; i++) begin
      sum_l2[i] = sum_l1[2*i] + sum_l1[2*i+1];
    end
    sum_l3 = sum_l2[0] + sum_l2[1];
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (!rst_n) begin
      mac_out_pvld <= 1'b0;
    end else begin
      mac_out_pvld <= prod_pvld;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (prod_pvld) begin
      mac_out_data <= sum_l3;
    end
  end

endmodule

`default_nettype wire

// File: cmac_rt_out.sv
// cmac output retiming
// per-cell result mask, descriptor alignment and layer end detect
`timescale 1ns/1ps
`default_nettype none

module cmac_rt_out #(
  parameter int RT_OUT_STAGES = 1
) (
  input  logic                                          nvdla_core_clk,
  input  logic                                          rst_n,
  input  cmac_pkg::result_t [cmac_pkg::CMAC_ATOMK-1:0]  out_data,
  input  logic [cmac_pkg::CMAC_ATOMK-1:0]               out_cell_pvld,
  input  logic [cmac_pkg::CMAC_ATOMK-1:0]               cell_loaded,
  input  logic [cmac_pkg::CMAC_PD_WIDTH-1:0]            out_pd,
  input  logic                                          out_pvld,
  output cmac_pkg::result_t [cmac_pkg::CMAC_ATOMK-1:0]  mac2accu_data,
  output logic [cmac_pkg::CMAC_ATOMK-1:0]               mac2accu_mask,
  output logic [cmac_pkg::CMAC_PD_WIDTH-1:0]            mac2accu_pd,
  output logic                                          mac2accu_pvld,
  output logic                                          out_layer_end
);

  localparam int S = RT_OUT_STAGES;
  localparam int K = cmac_pkg::CMAC_ATOMK;

  logic [K-1:0]                         mask_in;
  cmac_pkg::result_t [K-1:0]            data_in;
  logic [S-1:0]                         vld_q;
  logic [K-1:0]                         mask_q [S];
  cmac_pkg::result_t [K-1:0]            data_q [S];
  logic [cmac_pkg::CMAC_PD_WIDTH-1:0]   pd_q [S];

  // unloaded cells report zero
  always_comb begin
    for (int k = 0; k < K; k++) begin
      mask_in[k] = out_cell_pvld[k] & cell_loaded[k];
      if (mask_in[k]) begin
        data_in[k] = out_data[k];
      end else begin
        data_in[k] = '0;
      end
    end
  end

  // ==================================================
  // retiming stages
  // ==================================================
  always_ff @(posedge nvdla_core_clk) begin
    if (!rst_n) begin
      vld_q <= '0;
      for (int s = 0; s < S; s++) begin
        mask_q[s] <= '0;
      end
    end else begin
      vld_q[0] <= out_pvld;
      if (out_pvld) begin
        mask_q[0] <= mask_in;
      end
      for (int s = 1; s < S; s++) begin
        vld_q[s] <= vld_q[s-1];
        if (vld_q[s-1]) begin
          mask_q[s] <= mask_q[s-1];
        end
      end
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (out_pvld) begin
      data_q[0] <= data_in;
      pd_q[0]   <= out_pd;
    end
    for (int s = 1; s < S; s++) begin
      if (vld_q[s-1]) begin
        data_q[s] <= data_q[s-1];
        pd_q[s]   <= pd_q[s-1];
      end
    end
  end

  assign mac2accu_pvld = vld_q[S-1];
  assign mac2accu_mask = mask_q[S-1];
  assign mac2accu_data = data_q[S-1];
  assign mac2accu_pd   = pd_q[S-1];

  // last beat of the layer on the output
  assign out_layer_end = mac2accu_pvld & mac2accu_pd[cmac_pkg::PD_LAYER_END];

endmodule

`default_nettype wire

// File: cmac_core.sv
// cmac core top level
// input retiming, weight banks, mac cells and output retiming
`timescale 1ns/1ps
`default_nettype none

module cmac_core #(
  parameter int RT_IN_STAGES  = 1,
  parameter int RT_OUT_STAGES = 1
) (
  input  logic                                          nvdla_core_clk,
  input  logic                                          rst_n,
  input  logic                                          reg2dp_op_en,
  input  logic                                          sc2mac_dat_pvld,
  input  logic [cmac_pkg::CMAC_ATOMC-1:0]               sc2mac_dat_mask,
  input  cmac_pkg::beat_t                               sc2mac_dat_data,
  input  logic [cmac_pkg::CMAC_PD_WIDTH-1:0]            sc2mac_dat_pd,
  input  logic                                          sc2mac_wt_pvld,
  input  logic [cmac_pkg::CMAC_ATOMC-1:0]               sc2mac_wt_mask,
  input  cmac_pkg::beat_t                               sc2mac_wt_data,
  input  logic [cmac_pkg::CMAC_ATOMK-1:0]               sc2mac_wt_sel,
  output logic                                          dp2reg_done,
  output logic                                          mac2accu_pvld,
  output logic [cmac_pkg::CMAC_ATOMK-1:0]               mac2accu_mask,
  output logic [cmac_pkg::CMAC_PD_WIDTH-1:0]            mac2accu_pd,
  output cmac_pkg::result_t [cmac_pkg::CMAC_ATOMK-1:0]  mac2accu_data
);

  logic                                          op_start;
  logic                                          op_running;
  logic                                          out_layer_end;
  logic [cmac_pkg::CMAC_ATOMK-1:0]               cell_loaded;
  logic [cmac_pkg::CMAC_PD_WIDTH-1:0]            out_pd;
  logic                                          out_pvld;
  cmac_pkg::result_t [cmac_pkg::CMAC_ATOMK-1:0]  mac_data;
  logic [cmac_pkg::CMAC_ATOMK-1:0]               mac_pvld;

  cmac_dat_if dat_if ();
  cmac_wt_if  wt_if ();
  cmac_op_if  op_if [cmac_pkg::CMAC_ATOMK] ();

  // ==================================================
  // control
  // ==================================================
  cmac_cfg u_cfg (
    .nvdla_core_clk (nvdla_core_clk),
    .rst_n          (rst_n),
    .reg2dp_op_en   (reg2dp_op_en),
    .out_layer_end  (out_layer_end),
    .dp2reg_done    (dp2reg_done),
    .op_start       (op_start),
    .op_running     (op_running)
  );

  // ==================================================
  // datapath
  // ==================================================
  cmac_rt_in #(.RT_IN_STAGES(RT_IN_STAGES)) u_rt_in (
    .nvdla_core_clk  (nvdla_core_clk),
    .rst_n           (rst_n),
    .op_running      (op_running),
    .sc2mac_dat_pvld (sc2mac_dat_pvld),
    .sc2mac_dat_mask (sc2mac_dat_mask),
    .sc2mac_dat_data (sc2mac_dat_data),
    .sc2mac_dat_pd   (sc2mac_dat_pd),
    .sc2mac_wt_pvld  (sc2mac_wt_pvld),
    .sc2mac_wt_mask  (sc2mac_wt_mask),
    .sc2mac_wt_data  (sc2mac_wt_data),
    .sc2mac_wt_sel   (sc2mac_wt_sel),
    .dat             (dat_if.src),
    .wt              (wt_if.src)
  );

  cmac_active u_active (
    .nvdla_core_clk (nvdla_core_clk),
    .rst_n          (rst_n),
    .op_start       (op_start),
    .dat            (dat_if.dst),
    .wt             (wt_if.dst),
    .op             (op_if),
    .cell_loaded    (cell_loaded),
    .out_pd         (out_pd),
    .out_pvld       (out_pvld)
  );

  // one cell per output channel
  for (genvar k = 0; k < cmac_pkg::CMAC_ATOMK; k++) begin : u_mac
    cmac_mac_cell u_cell (
      .nvdla_core_clk (nvdla_core_clk),
      .rst_n          (rst_n),
      .op             (op_if[k]),
      .mac_out_data   (mac_data[k]),
      .mac_out_pvld   (mac_pvld[k])
    );
  end

  cmac_rt_out #(.RT_OUT_STAGES(RT_OUT_STAGES)) u_rt_out (
    .nvdla_core_clk (nvdla_core_clk),
    .rst_n          (rst_n),
    .out_data       (mac_data),
    .out_cell_pvld  (mac_pvld),
    .cell_loaded    (cell_loaded),
    .out_pd         (out_pd),
    .out_pvld       (out_pvld),
    .mac2accu_data  (mac2accu_data),
    .mac2accu_mask  (mac2accu_mask),
    .mac2accu_pd    (mac2accu_pd),
    .mac2accu_pvld  (mac2accu_pvld),
    .out_layer_end  (out_layer_end)
  );

endmodule

`default_nettype wire

// File: tb_cmac_core.sv
// cmac_core testbench
// random weights and stripes against a scoreboard model, op_en/done handshake
`timescale 1ns/1ps
`default_nettype none

module tb_cmac_core;

  localparam int C = cmac_pkg::CMAC_ATOMC;
  localparam int K = cmac_pkg::CMAC_ATOMK;
  localparam int PDW = cmac_pkg::CMAC_PD_WIDTH;
  localparam int CLK_PERIOD = 8;
  localparam int RESET_CYCLES = 10;
  localparam int STRIPES = 4;
  localparam int BEATS = 6;
  // two ops, each stripe has weight loads plus data beats
  localparam int TOTAL_BEATS = 2 * STRIPES * (K + BEATS);
  localparam int MARGIN_CYCLES = 200;
  localparam int WATCHDOG_NS = (RESET_CYCLES + TOTAL_BEATS + MARGIN_CYCLES) * CLK_PERIOD;

  typedef struct {
    cmac_pkg::result_t [K-1:0] data;
    logic [K-1:0]              mask;
    logic [PDW-1:0]            pd;
    int                        due;
  } sb_entry_t;

  logic clk = 1'b0;
  logic rst_n;
  logic reg2dp_op_en;
  logic sc2mac_dat_pvld;
  logic [C-1:0] sc2mac_dat_mask;
  cmac_pkg::beat_t sc2mac_dat_data;
  logic [PDW-1:0] sc2mac_dat_pd;
  logic sc2mac_wt_pvld;
  logic [C-1:0] sc2mac_wt_mask;
  cmac_pkg::beat_t sc2mac_wt_data;
  logic [K-1:0] sc2mac_wt_sel;
  logic dp2reg_done;
  logic mac2accu_pvld;
  logic [K-1:0] mac2accu_mask;
  logic [PDW-1:0] mac2accu_pd;
  cmac_pkg::result_t [K-1:0] mac2accu_data;

  // reference model state, shadow and active banks per cell
  cmac_pkg::beat_t sh_w [K];
  cmac_pkg::beat_t act_w [K];
  logic [C-1:0] sh_m [K];
  logic [C-1:0] act_m [K];
  logic [K-1:0] written = '0;
  logic [K-1:0] loaded = '0;
  bit model_running = 1'b0;

  sb_entry_t sb [$];
  string test_name = "idle";
  int lat;
  int cyc = 0;
  int rst_age = 0;
  bit rst_seen = 1'b0;
  int errors = 0;
  int checks = 0;
  int pushed = 0;
  logic masked_nonzero;

  cmac_core i_dut (
    .nvdla_core_clk  (clk),
    .rst_n           (rst_n),
    .reg2dp_op_en    (reg2dp_op_en),
    .sc2mac_dat_pvld (sc2mac_dat_pvld),
    .sc2mac_dat_mask (sc2mac_dat_mask),
    .sc2mac_dat_data (sc2mac_dat_data),
    .sc2mac_dat_pd   (sc2mac_dat_pd),
    .sc2mac_wt_pvld  (sc2mac_wt_pvld),
    .sc2mac_wt_mask  (sc2mac_wt_mask),
    .sc2mac_wt_data  (sc2mac_wt_data),
    .sc2mac_wt_sel   (sc2mac_wt_sel),
    .dp2reg_done     (dp2reg_done),
    .mac2accu_pvld   (mac2accu_pvld),
    .mac2accu_mask   (mac2accu_mask),
    .mac2accu_pd     (mac2accu_pd),
    .mac2accu_data   (mac2accu_data)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // cycle count and time since reset release
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (!rst_n) begin
      rst_seen <= 1'b1;
      rst_age  <= 0;
    end else begin
      rst_age <= rst_age + 1;
    end
  end

  // ==================================================
  // reference model helpers
  // ==================================================
  function automatic logic [7:0] rand_byte();
    return 8'($urandom);
  endfunction

  function automatic cmac_pkg::beat_t rand_beat();
    cmac_pkg::beat_t b;
    for (int c = 0; c < C; c++) begin
      b[c] = 8'($urandom);
    end
    return b;
  endfunction

  // signed sum over channels where both mask bits are set
  function automatic cmac_pkg::result_t dot_product(input cmac_pkg::beat_t d,
      input logic [C-1:0] dm, input cmac_pkg::beat_t w, input logic [C-1:0] wm);
    int acc;
    acc = 0;
    for (int c = 0; c < C; c++) begin
      if (dm[c] && wm[c]) begin
        acc += int'(d[c]) * int'(w[c]);
      end
    end
    return cmac_pkg::result_t'(acc);
  endfunction

  // ==================================================
  // stimulus, one clock per call
  // ==================================================
  task automatic step(input bit dv, input logic [C-1:0] dm, input cmac_pkg::beat_t dd,
      input logic [PDW-1:0] dpd, input bit wv, input logic [C-1:0] wm,
      input cmac_pkg::beat_t wd, input logic [K-1:0] ws);
    sb_entry_t e;
    @(posedge clk);
    sc2mac_dat_pvld <= dv;
    sc2mac_dat_mask <= dm;
    sc2mac_dat_data <= dd;
    sc2mac_dat_pd   <= dpd;
    sc2mac_wt_pvld  <= wv;
    sc2mac_wt_mask  <= wm;
    sc2mac_wt_data  <= wd;
    sc2mac_wt_sel   <= ws;
    // data beats count only while the op runs
    if (dv && model_running) begin
      // stripe start promotes before its own beat is used
      if (dpd[cmac_pkg::PD_STRIPE_ST]) begin
        for (int k = 0; k < K; k++) begin
          act_w[k] = sh_w[k];
          act_m[k] = sh_m[k];
        end
        loaded = loaded | written;
      end
      e.pd  = dpd;
      e.due = cyc + 1 + lat;
      for (int k = 0; k < K; k++) begin
        e.mask[k] = loaded[k];
        e.data[k] = loaded[k] ? dot_product(dd, dm, act_w[k], act_m[k]) : '0;
      end
      sb.push_back(e);
      pushed++;
    end
    // shadow write lands after any same-cycle promotion
    if (wv) begin
      for (int k = 0; k < K; k++) begin
        if (ws[k]) begin
          sh_w[k]    = wd;
          sh_m[k]    = wm;
          written[k] = 1'b1;
        end
      end
    end
  endtask

  task automatic idle_cycle();
    step(1'b0, '0, '0, '0, 1'b0, '0, '0, '0);
  endtask

  // data beat with a stripe start, ignored unless running
  task automatic stray_beat();
    logic [PDW-1:0] pd;
    pd = 9'($urandom);
    pd[cmac_pkg::PD_STRIPE_ST] = 1'b1;
    step(1'b1, rand_byte(), rand_beat(), pd, 1'b0, '0, '0, '0);
  endtask

  task automatic run_stripe(input logic [K-1:0] cells, input bit reload, input bit last);
    logic [PDW-1:0] pd;
    bit wv;
    logic [K-1:0] ws;
    if (reload) begin
      for (int k = 0; k < K; k++) begin
        if (cells[k]) begin
          step(1'b0, '0, '0, '0, 1'b1, rand_byte(), rand_beat(), 4'(1 << k));
        end
      end
    end
    for (int b = 0; b < BEATS; b++) begin
      pd = 9'($urandom);
      pd[cmac_pkg::PD_STRIPE_ST]  = (b == 0);
      pd[cmac_pkg::PD_STRIPE_END] = (b == BEATS - 1);
      pd[cmac_pkg::PD_LAYER_END]  = last && (b == BEATS - 1);
      // mid stripe rewrite, cell b-1 on beat b
      wv = (b >= 1) && (b <= K) && cells[(b >= 1 && b <= K) ? b - 1 : 0];
      ws = wv ? 4'(1 << (b - 1)) : '0;
      step(1'b1, rand_byte(), rand_beat(), pd, wv, rand_byte(), rand_beat(), ws);
    end
  endtask

  task automatic run_op(input string name, input logic [K-1:0] cells);
    test_name = name;
    @(posedge clk);
    reg2dp_op_en    <= 1'b1;
    sc2mac_dat_pvld <= 1'b0;
    sc2mac_wt_pvld  <= 1'b0;
    loaded        = '0;
    model_running = 1'b1;
    idle_cycle();
    idle_cycle();
    // odd stripes run on the mid stripe rewrites
    for (int s = 0; s < STRIPES; s++) begin
      run_stripe(cells, (s % 2) == 0, s == STRIPES - 1);
    end
    model_running = 1'b0;
    while (sb.size() != 0) begin
      idle_cycle();
    end
    while (!dp2reg_done) begin
      idle_cycle();
    end
    // done holds while op_en stays high
    repeat (3) stray_beat();
    repeat (3) idle_cycle();
    @(posedge clk);
    reg2dp_op_en    <= 1'b0;
    sc2mac_dat_pvld <= 1'b0;
    while (dp2reg_done) begin
      idle_cycle();
    end
    repeat (3) stray_beat();
    repeat (lat + 2) idle_cycle();
  endtask

  // ==================================================
  // checks
  // ==================================================
  always_comb begin
    masked_nonzero = 1'b0;
    for (int k = 0; k < K; k++) begin
      if (!mac2accu_mask[k] && mac2accu_data[k] != '0) begin
        masked_nonzero = 1'b1;
      end
    end
  end

  reset_quiet: assert property (@(posedge clk) (rst_seen && rst_age < 3) |->
      (!mac2accu_pvld && !dp2reg_done && mac2accu_mask == '0))
    else begin
      errors++;
      $display("mismatch reset_values: expected 0, actual pvld=%0b done=%0b mask=%b",
               mac2accu_pvld, dp2reg_done, mac2accu_mask);
    end

  masked_zero: assert property (@(posedge clk) disable iff (!rst_n)
      mac2accu_pvld |-> !masked_nonzero)
    else begin
      errors++;
      $display("mismatch %s masked_cells: expected data 0, actual %h", test_name,
               mac2accu_data);
    end

  done_after_layer_end: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(dp2reg_done) |-> $past(mac2accu_pvld && mac2accu_pd[cmac_pkg::PD_LAYER_END]))
    else begin
      errors++;
      $display("error: done rose without a layer end beat on the previous cycle");
    end

  done_hold: assert property (@(posedge clk) disable iff (!rst_n)
      $past(dp2reg_done && reg2dp_op_en) |-> dp2reg_done)
    else begin
      errors++;
      $display("error: done dropped while op_en was still high");
    end

  done_release: assert property (@(posedge clk) disable iff (!rst_n)
      $past(dp2reg_done && !reg2dp_op_en) |-> !dp2reg_done)
    else begin
      errors++;
      $display("error: done stayed high after op_en dropped");
    end

  // scoreboard compare on every output beat
  always @(posedge clk) begin : check_out
    sb_entry_t exp;
    if (rst_n && mac2accu_pvld) begin
      if (sb.size() == 0) begin
        errors++;
        $display("error: output beat at cycle %0d with no input beat pending", cyc);
      end else begin
        exp = sb.pop_front();
        checks++;
        assert (cyc == exp.due) else begin
          errors++;
          $display("mismatch %s latency: expected cycle %0d, actual cycle %0d",
                   test_name, exp.due, cyc);
        end
        assert (mac2accu_pd == exp.pd) else begin
          errors++;
          $display("mismatch %s pd: expected %h, actual %h", test_name, exp.pd, mac2accu_pd);
        end
        assert (mac2accu_mask == exp.mask) else begin
          errors++;
          $display("mismatch %s mask: expected %b, actual %b", test_name, exp.mask,
                   mac2accu_mask);
        end
        for (int k = 0; k < K; k++) begin
          assert (mac2accu_data[k] == exp.data[k]) else begin
            errors++;
            $display("mismatch %s cell %0d data: expected %0d, actual %0d", test_name, k,
                     exp.data[k], mac2accu_data[k]);
          end
        end
      end
    end
  end

  // ==================================================
  // main sequence and watchdog
  // ==================================================
  initial begin
    void'($urandom(32'h93ee_9994));
    lat = i_dut.RT_IN_STAGES + 3 + i_dut.RT_OUT_STAGES;
    rst_n           = 1'b0;
    reg2dp_op_en    = 1'b0;
    sc2mac_dat_pvld = 1'b0;
    sc2mac_dat_mask = '0;
    sc2mac_dat_data = '0;
    sc2mac_dat_pd   = '0;
    sc2mac_wt_pvld  = 1'b0;
    sc2mac_wt_mask  = '0;
    sc2mac_wt_data  = '0;
    sc2mac_wt_sel   = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    repeat (3) idle_cycle();
    // idle beats must not reach the output
    repeat (3) stray_beat();
    repeat (lat + 2) idle_cycle();
    // cell 3 is never written in the first op
    run_op("op1_partial_cells", 4'b0111);
    run_op("op2_all_cells", 4'b1111);
    if (checks != pushed) begin
      errors++;
      $display("error: %0d input beats sent but %0d output beats seen", pushed, checks);
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("error: run hung, timeout after %0d ns with %0d errors so far", WATCHDOG_NS,
             errors);
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: cmac.f
cmac_pkg.sv
cmac_if.sv
cmac_cfg.sv
cmac_rt_in.sv
cmac_active.sv
cmac_mac_cell.sv
cmac_rt_out.sv
cmac_core.sv
tb_cmac_core.sv

// File: run_sim.sh
#!/bin/sh
# build and run the cmac_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f cmac.f \
  --top-module tb_cmac_core -o tb_cmac_core > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/tb_cmac_core > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the testbench prints the fail message on any failure
if grep -q "sim failed" "$SIM_LOG"; then
  exit 1
fi
exit 0
